// ==== flist.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/ea_mode_decode.sv
hdl/imm_size_decode.sv
hdl/ea_fetch_route.sv
hdl/start_op_dispatch.sv
hdl/fetch_start_top.sv
verif/tb_clock.sv
verif/tb_fetch_start.sv

// ==== Bender.yml ====
package:
  name: fetch_start

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/ea_mode_decode.sv
      - hdl/imm_size_decode.sv
      - hdl/ea_fetch_route.sv
      - hdl/start_op_dispatch.sv
      - hdl/fetch_start_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/tb_fetch_start.sv

// ==== verif/tb_fetch_start.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_start;
    import fetch_pkg::*;

    localparam int PERIOD_NS   = 40;
    localparam int RST_CYCLES  = 5;
    localparam int DRIVE_DLY   = 2;
    localparam int NUM_DIRECT  = 6;
    localparam int NUM_RANDOM  = 4000;
    localparam int NUM_VECTORS = NUM_DIRECT + NUM_RANDOM;
    localparam int WATCHDOG_NS = (NUM_VECTORS + RST_CYCLES + 20) * PERIOD_NS;

    logic         clk;
    logic         rst_n;
    start_req_t   req;
    avail_t       avail;
    hazard_t      haz;
    fetch_state_t next_fetch_state;
    fetch_state_t exp_now;
    fetch_state_t exp_q;
    int           errors;
    logic [31:0]  rng;

    tb_clock #(
        .PERIOD_NS  (PERIOD_NS),
        .RST_CYCLES (RST_CYCLES)
    ) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_start_top DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .req              (req),
        .avail            (avail),
        .haz              (haz),
        .next_fetch_state (next_fetch_state)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic ea_mode_t classify_ea(biw_t w);
        case (w[5:3])
            3'b000:         return EA_DN;
            3'b001:         return EA_AN;
            3'b010, 3'b011: return EA_IND;
            3'b100:         return EA_PREDEC;
            3'b101:         return EA_DISP16;
            3'b110:         return EA_INDEX;
            default: begin
                if (w[2:0] == 3'b000) return EA_ABS_W;
                if (w[2:0] == 3'b001) return EA_ABS_L;
                if (w[2:0] == 3'b010) return EA_PC_DISP;
                if (w[2:0] == 3'b100) return EA_IMM;
                return EA_PC_INDEX;       // PC index and the reserved codes.
            end
        endcase
    endfunction

    function automatic logic is_alu_dst(fetch_op_t op);
        return op inside {ADD, ADDI, ADDQ, AND_B, ANDI, CMP, CMPI, EOR, EORI, NBCD,
                          NEG, NEGX, NOT_B, OR_B, ORI, SUB, SUBI, SUBQ, TST, TAS};
    endfunction

    function automatic logic is_src_opd(fetch_op_t op);
        return op inside {ADDA, BCHG, BCLR, BSET, BTST, CHK, CHK2, CMP2, CMPA, DIVS,
                          DIVU, MULS, MULU, MOVEA, MOVE_TO_CCR, MOVE_TO_SR, SUBA};
    endfunction

    // Size of an immediate source, per operation group.
    function automatic logic long_imm(fetch_op_t op, biw_t w);
        if (is_alu_dst(op)) return w[7:6] == 2'b10;
        if (op inside {ADDA, CMPA, SUBA}) return w[8:7] == 2'b11;
        if (op inside {MOVEA, MOVE}) return w[13:12] == 2'b10;
        if (op == CHK) return w[8:7] == 2'b10;
        if (op inside {CHK2, CMP2}) return w[10:9] == 2'b10;
        if (op inside {DIVS, DIVU, MULS, MULU}) return !w[7];
        return 1'b0;
    endfunction

    function automatic fetch_state_t mem_target(ea_mode_t m, logic lng, logic ar_busy);
        case (m)
            EA_IND:                return ar_busy ? START_OP : FETCH_OPERAND;
            EA_PREDEC:             return ar_busy ? START_OP : CALC_AEFF;
            EA_DISP16, EA_PC_DISP: return FETCH_DISPL;
            EA_INDEX, EA_PC_INDEX: return FETCH_EXWORD_1;
            EA_ABS_W:              return FETCH_ABS_LO;
            EA_ABS_L:              return FETCH_ABS_HI;
            EA_IMM:                return lng ? FETCH_IDATA_B2 : FETCH_IDATA_B1;
            default:               return INIT_EXEC_WB;
        endcase
    endfunction

    function automatic fetch_state_t expect_state(start_req_t r, avail_t a, hazard_t h);
        ea_mode_t     m;
        fetch_state_t mem;
        logic         dn_wait;
        logic         an_wait;
        m   = classify_ea(r.biw_0);
        mem = mem_target(m, long_imm(r.op, r.biw_0), h.ar_in_use);
        if (!a.opd_ack && !a.ow_rdy) return START_OP;
        if (r.op inside {ILLEGAL, RTE, TRAP, UNIMPLEMENTED}) return START_OP;
        if (r.op inside {DBCC, EXT, EXTB, MOVEQ, SWAP}) begin
            return h.dr_in_use ? START_OP : INIT_EXEC_WB;
        end
        if (r.op inside {ANDI_TO_CCR, ANDI_TO_SR, EORI_TO_CCR, EORI_TO_SR,
                         ORI_TO_CCR, ORI_TO_SR, OP_RESET}) begin
            return h.alu_bsy ? START_OP : INIT_EXEC_WB;
        end
        if (r.op inside {ASL, ASR, LSL, LSR, ROTL, ROTR, ROXL, ROXR}) begin
            if (r.biw_0[7:6] != 2'b11) return h.dr_in_use ? START_OP : INIT_EXEC_WB;
            if (m inside {EA_IND, EA_PREDEC, EA_DISP16, EA_INDEX}) return mem;
            return (r.biw_0[2:0] == 3'b000) ? FETCH_ABS_LO : FETCH_ABS_HI;
        end
        if (is_alu_dst(r.op) || is_src_opd(r.op) || r.op == MOVE) begin
            dn_wait = h.dr_in_use;
            an_wait = h.ar_in_use;
            if (r.op inside {ADD, SUB, AND_B, EOR, OR_B, CMP}) begin
                an_wait = an_wait || h.dr_in_use;   // An form reads a Dn as well.
            end
            if (r.op inside {ADDA, SUBA, CMPA, MOVEA}) begin
                dn_wait = dn_wait || h.ar_in_use;
            end
            if (r.op == MOVE && r.biw_0[8:6] == 3'b100) begin
                dn_wait = dn_wait || h.ar_in_use;   // -(An) destination.
            end
            if (m == EA_DN) return dn_wait ? START_OP : INIT_EXEC_WB;
            if (m == EA_AN) return an_wait ? START_OP : INIT_EXEC_WB;
            return mem;
        end
        return INIT_EXEC_WB;
    endfunction

    always_comb begin
        exp_now = expect_state(req, avail, haz);
    end

    // Expected output lines up with the DUT register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q <= START_OP;
        end else begin
            exp_q <= exp_now;
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> next_fetch_state == START_OP)
        else begin
            errors++;
            $display("CHECK FAILED next_fetch_state in reset: got %h expected %h",
                     $sampled(next_fetch_state), START_OP);
        end

    a_first_edge: assert property (@(posedge clk) $rose(rst_n) |-> next_fetch_state == START_OP)
        else begin
            errors++;
            $display("CHECK FAILED next_fetch_state after reset: got %h expected %h",
                     $sampled(next_fetch_state), START_OP);
        end

    a_model_match: assert property (@(posedge clk) disable iff (!rst_n)
        next_fetch_state == exp_q)
        else begin
            errors++;
            $display("CHECK FAILED next_fetch_state: got %h expected %h",
                     $sampled(next_fetch_state), $sampled(exp_q));
        end

    task automatic drive_vector(input start_req_t r, input avail_t a, input hazard_t h);
        @(posedge clk);
        #DRIVE_DLY;
        req   = r;
        avail = a;
        haz   = h;
    endtask

    task automatic drive_random();
        start_req_t r;
        avail_t     a;
        hazard_t    h;
        rng     = xorshift32(rng);
        r.op    = fetch_op_t'(rng[15:0] % (int'(OP_RESET) + 1));
        r.biw_0 = rng[29:16];
        rng     = xorshift32(rng);
        if (rng[1:0] == 2'b00) begin
            r.biw_0[5:3] = 3'b111;            // Special modes show up more often.
        end
        if (rng[4:2] == 3'b000) begin
            a = avail_t'(2'b00);
        end else begin
            a = (rng[6:5] == 2'b00) ? avail_t'(2'b11) : avail_t'(rng[6:5]);
        end
        h = hazard_t'(rng[9:7]);
        drive_vector(r, a, h);
    endtask

    initial begin
        errors = 0;
        rng    = 32'hcc53;
        req    = '0;
        avail  = '0;
        haz    = '0;
        wait (rst_n === 1'b1);
        drive_vector('{op: TRAP, biw_0: 14'h0}, avail_t'(2'b00), hazard_t'(3'b111));
        drive_vector('{op: ORI_TO_SR, biw_0: 14'h0}, avail_t'(2'b01), hazard_t'(3'b001));
        drive_vector('{op: ORI_TO_SR, biw_0: 14'h0}, avail_t'(2'b10), hazard_t'(3'b110));
        drive_vector('{op: ASL, biw_0: 14'h00f9}, avail_t'(2'b11), hazard_t'(3'b000));
        drive_vector('{op: ADDI, biw_0: 14'h00bc}, avail_t'(2'b11), hazard_t'(3'b000));
        drive_vector('{op: MOVE, biw_0: 14'h303c}, avail_t'(2'b11), hazard_t'(3'b000));
        repeat (NUM_RANDOM) drive_random();
        drive_vector('0, avail_t'(2'b00), hazard_t'(3'b000));
        repeat (2) @(posedge clk);
        #1;
        $display("fetch start run: %0d vectors, %0d errors", NUM_VECTORS, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish within %0d ns.", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b1;
        #1;
        rst_n = 1'b0;                     // Reset edge clear of time zero.
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;                     // Released just clear of the edge.
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_start_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_start_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::start_req_t   req,
    input  fetch_pkg::avail_t       avail,
    input  fetch_pkg::hazard_t      haz,
    output fetch_pkg::fetch_state_t next_fetch_state
);
    import fetch_pkg::*;

    ea_mode_t     mode;
    logic         imm_long;
    fetch_state_t route_state;
    fetch_state_t decision;

    ea_mode_decode u_mode (
        .biw_0 (req.biw_0),
        .mode  (mode)
    );

    imm_size_decode u_imm (
        .req      (req),
        .imm_long (imm_long)
    );

    ea_fetch_route u_route (
        .mode        (mode),
        .imm_long    (imm_long),
        .ar_in_use   (haz.ar_in_use),
        .route_state (route_state)
    );

    start_op_dispatch u_dispatch (
        .req         (req),
        .avail       (avail),
        .haz         (haz),
        .mode        (mode),
        .route_state (route_state),
        .decision    (decision)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_fetch_state <= START_OP;
        end else begin
            next_fetch_state <= decision;     // One cycle after sampling.
        end
    end

    a_no_data_waits: assert property (@(posedge clk) disable iff (!rst_n)
        (!avail.opd_ack && !avail.ow_rdy) |=> (next_fetch_state == START_OP))
        else $error("fetch start left START_OP without data");

    a_legal_state: assert property (@(posedge clk) disable iff (!rst_n)
        next_fetch_state inside {START_OP, CALC_AEFF, FETCH_DISPL, FETCH_EXWORD_1,
                                 FETCH_ABS_HI, FETCH_ABS_LO, FETCH_IDATA_B2,
                                 FETCH_IDATA_B1, FETCH_OPERAND, INIT_EXEC_WB})
        else $error("illegal fetch state %0h", next_fetch_state);

    a_trap_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (req.op inside {ILLEGAL, RTE, TRAP, UNIMPLEMENTED}) |=> (next_fetch_state == START_OP))
        else $error("trap group did not return to START_OP");

endmodule

`default_nettype wire

// ==== hdl/start_op_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module start_op_dispatch (
    input  fetch_pkg::start_req_t   req,
    input  fetch_pkg::avail_t       avail,
    input  fetch_pkg::hazard_t      haz,
    input  fetch_pkg::ea_mode_t     mode,
    input  fetch_pkg::fetch_state_t route_state,
    output fetch_pkg::fetch_state_t decision
);
    import fetch_pkg::*;

    logic add_type;
    logic adda_type;
    logic move_predec;
    logic shift_mem;

    // Dyadic ALU ops whose An form also reads a data register.
    assign add_type    = req.op inside {ADD, SUB, AND_B, EOR, OR_B, CMP};
    assign adda_type   = req.op inside {ADDA, SUBA, CMPA, MOVEA};
    assign move_predec = (req.biw_0[8:6] == 3'b100); // MOVE to -(An).
    assign shift_mem   = (req.biw_0[7:6] == 2'b11);  // Memory shift form.

    always_comb begin
        if (!avail.opd_ack && !avail.ow_rdy) begin
            decision = START_OP;                      // Nothing to work on yet.
        end else begin
            case (req.op)
                ILLEGAL, RTE, TRAP, UNIMPLEMENTED: begin
                    decision = START_OP;
                end
                DBCC, EXT, EXTB, MOVEQ, SWAP: begin
                    if (haz.dr_in_use) begin
                        decision = START_OP;          // Wait, data hazard.
                    end else begin
                        decision = INIT_EXEC_WB;
                    end
                end
                ADD, ADDI, ADDQ, AND_B, ANDI, CMP, CMPI, EOR, EORI,
                NBCD, NEG, NEGX, NOT_B, OR_B, ORI, SUB, SUBI, SUBQ,
                TST, TAS: begin
                    // Destination is an ALU operand, so it is hazard checked.
                    case (mode)
                        EA_DN: begin
                            decision = haz.dr_in_use ? START_OP : INIT_EXEC_WB;
                        end
                        EA_AN: begin
                            if (haz.ar_in_use || (add_type && haz.dr_in_use)) begin
                                decision = START_OP;
                            end else begin
                                decision = INIT_EXEC_WB;
                            end
                        end
                        default: decision = route_state;
                    endcase
                end
                ADDA, BCHG, BCLR, BSET, BTST, CHK, CHK2, CMP2, CMPA,
                DIVS, DIVU, MULS, MULU, MOVEA, MOVE_TO_CCR,
                MOVE_TO_SR, SUBA: begin
                    case (mode)
                        EA_DN: begin
                            if (haz.dr_in_use || (adda_type && haz.ar_in_use)) begin
                                decision = START_OP;
                            end else begin
                                decision = INIT_EXEC_WB;
                            end
                        end
                        EA_AN: begin
                            decision = haz.ar_in_use ? START_OP : INIT_EXEC_WB;
                        end
                        default: decision = route_state;
                    endcase
                end
                MOVE: begin
                    case (mode)
                        EA_DN: begin
                            // A -(An) destination gets decremented right away.
                            if (haz.dr_in_use || (move_predec && haz.ar_in_use)) begin
                                decision = START_OP;
                            end else begin
                                decision = INIT_EXEC_WB;
                            end
                        end
                        EA_AN: begin
                            decision = haz.ar_in_use ? START_OP : INIT_EXEC_WB;
                        end
                        default: decision = route_state;
                    endcase
                end
                ASL, ASR, LSL, LSR, ROTL, ROTR, ROXL, ROXR: begin
                    if (!shift_mem) begin
                        decision = haz.dr_in_use ? START_OP : INIT_EXEC_WB;
                    end else begin
                        case (mode)
                            EA_IND, EA_PREDEC, EA_DISP16, EA_INDEX: begin
                                decision = route_state;
                            end
                            default: begin
                                if (req.biw_0[2:0] == 3'b000) begin
                                    decision = FETCH_ABS_LO;  // Short absolute.
                                end else begin
                                    decision = FETCH_ABS_HI;
                                end
                            end
                        endcase
                    end
                end
                ANDI_TO_CCR, ANDI_TO_SR, EORI_TO_CCR, EORI_TO_SR,
                ORI_TO_CCR, ORI_TO_SR, OP_RESET: begin
                    // Condition codes must settle before they are used again.
                    decision = haz.alu_bsy ? START_OP : INIT_EXEC_WB;
                end
                default: begin
                    decision = INIT_EXEC_WB;          // Bcc, BRA, NOP, STOP, TRAPV.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ea_fetch_route.sv ====
`timescale 1ns/1ps
`default_nettype none

module ea_fetch_route (
    input  fetch_pkg::ea_mode_t     mode,
    input  logic                    imm_long,
    input  logic                    ar_in_use,
    output fetch_pkg::fetch_state_t route_state
);
    import fetch_pkg::*;

    always_comb begin
        case (mode)
            EA_IND: begin
                if (ar_in_use) begin
                    route_state = START_OP;      // Wait, address hazard.
                end else begin
                    route_state = FETCH_OPERAND;
                end
            end
            EA_PREDEC: begin
                if (ar_in_use) begin
                    route_state = START_OP;      // Wait, address hazard.
                end else begin
                    route_state = CALC_AEFF;     // Decrement first.
                end
            end
            EA_DISP16, EA_PC_DISP: begin
                route_state = FETCH_DISPL;
            end
            EA_INDEX, EA_PC_INDEX: begin
                route_state = FETCH_EXWORD_1;
            end
            EA_ABS_W: begin
                route_state = FETCH_ABS_LO;      // Only low word follows.
            end
            EA_ABS_L: begin
                route_state = FETCH_ABS_HI;
            end
            EA_IMM: begin
                if (imm_long) begin
                    route_state = FETCH_IDATA_B2;
                end else begin
                    route_state = FETCH_IDATA_B1; // Word or byte.
                end
            end
            default: begin
                route_state = INIT_EXEC_WB;      // Register direct.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/imm_size_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_size_decode (
    input  fetch_pkg::start_req_t req,
    output logic                  imm_long
);
    import fetch_pkg::*;

    biw_t biw;

    assign biw = req.biw_0;

    // Long immediate rule per operation group.
    always_comb begin
        case (req.op)
            ADD, ADDI, ADDQ, AND_B, ANDI, CMP, CMPI, EOR, EORI,
            NBCD, NEG, NEGX, NOT_B, OR_B, ORI, SUB, SUBI, SUBQ,
            TST, TAS: begin
                imm_long = (biw[7:6] == 2'b10);  // Standard size field.
            end
            ADDA, CMPA, SUBA:       imm_long = (biw[8:7] == 2'b11);
            MOVEA, MOVE:            imm_long = (biw[13:12] == 2'b10);
            CHK:                    imm_long = (biw[8:7] == 2'b10);
            CHK2, CMP2:             imm_long = (biw[10:9] == 2'b10);
            DIVS, DIVU, MULS, MULU: imm_long = !biw[7]; // Long form only.
            default:                imm_long = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ea_mode_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module ea_mode_decode (
    input  fetch_pkg::biw_t     biw_0,
    output fetch_pkg::ea_mode_t mode
);
    import fetch_pkg::*;

    logic [2:0] mode_field;
    logic [2:0] reg_field;

    assign mode_field = biw_0[5:3];
    assign reg_field  = biw_0[2:0];

    always_comb begin
        case (mode_field)
            3'b000:         mode = EA_DN;
            3'b001:         mode = EA_AN;
            3'b010, 3'b011: mode = EA_IND;     // Postincrement reads like (An).
            3'b100:         mode = EA_PREDEC;
            3'b101:         mode = EA_DISP16;
            3'b110:         mode = EA_INDEX;
            default: begin
                // Mode 7 uses the register field as a sub-mode.
                case (reg_field)
                    3'b000:  mode = EA_ABS_W;
                    3'b001:  mode = EA_ABS_L;
                    3'b010:  mode = EA_PC_DISP;
                    3'b100:  mode = EA_IMM;
                    default: mode = EA_PC_INDEX; // PC index and reserved.
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

`include "fetch_params.svh"

    typedef logic [`BIW_W-1:0] biw_t;

    typedef enum logic [`OP_W-1:0] {
        NOP, BCC, BRA, STOP, TRAPV,                          // Plain execute.
        ILLEGAL, RTE, TRAP, UNIMPLEMENTED,                   // Trap group.
        DBCC, EXT, EXTB, MOVEQ, SWAP,                        // Register only.
        ADD, ADDI, ADDQ, AND_B, ANDI, CMP, CMPI, EOR, EORI,
        NBCD, NEG, NEGX, NOT_B, OR_B, ORI, SUB, SUBI, SUBQ,
        TST, TAS,                                            // ALU destination.
        ADDA, BCHG, BCLR, BSET, BTST, CHK, CHK2, CMP2, CMPA,
        DIVS, DIVU, MULS, MULU, MOVEA, MOVE_TO_CCR,
        MOVE_TO_SR, SUBA,                                    // Source operand.
        MOVE,
        ASL, ASR, LSL, LSR, ROTL, ROTR, ROXL, ROXR,          // Shift and rotate.
        ANDI_TO_CCR, ANDI_TO_SR, EORI_TO_CCR, EORI_TO_SR,
        ORI_TO_CCR, ORI_TO_SR, OP_RESET                      // Status register.
    } fetch_op_t;

    typedef enum logic [`FETCH_STATE_W-1:0] {
        START_OP       = 5'd0,
        CALC_AEFF      = 5'd1,
        FETCH_DISPL    = 5'd2,
        FETCH_EXWORD_1 = 5'd3,
        FETCH_ABS_HI   = 5'd8,
        FETCH_ABS_LO   = 5'd9,
        FETCH_IDATA_B2 = 5'd10,
        FETCH_IDATA_B1 = 5'd11,
        FETCH_OPERAND  = 5'd13,
        INIT_EXEC_WB   = 5'd14
    } fetch_state_t;

    typedef enum logic [`EA_MODE_W-1:0] {
        EA_DN,
        EA_AN,
        EA_IND,       // (An) and (An)+.
        EA_PREDEC,    // -(An).
        EA_DISP16,
        EA_INDEX,
        EA_ABS_W,
        EA_ABS_L,
        EA_PC_DISP,
        EA_IMM,
        EA_PC_INDEX   // Reserved codes land here too.
    } ea_mode_t;

    typedef struct packed {
        fetch_op_t op;
        biw_t      biw_0;
    } start_req_t;

    typedef struct packed {
        logic opd_ack;
        logic ow_rdy;
    } avail_t;

    typedef struct packed {
        logic dr_in_use;
        logic ar_in_use;
        logic alu_bsy;
    } hazard_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Fetch FSM state code.
`define FETCH_STATE_W 5

// Decoded operation code.
`define OP_W 7

// Kept part of the first instruction word.
`define BIW_W 14

// Addressing mode class.
`define EA_MODE_W 4

`endif
